// ==== source/core_pkg.sv ====
/* widths, vectors and MIPS32 encodings shared by the three-step integer core
   only the listed subset decodes and other encodings run as no-ops */
package core_pkg;

    localparam int data_width     = 32;
    localparam int reg_addr_width = 5;
    localparam int int_width      = 6;     // external interrupt lines

    typedef logic [data_width-1:0]     word_t;
    typedef logic [reg_addr_width-1:0] reg_addr_t;

    localparam word_t reset_vector = 32'hbfc0_0000;
    localparam word_t exc_vector   = 32'hbfc0_0380;    // BEV=1 general entry

    // cp0 register numbers
    localparam reg_addr_t cp0_status = 5'd12;
    localparam reg_addr_t cp0_cause  = 5'd13;
    localparam reg_addr_t cp0_epc    = 5'd14;

    localparam int status_ie_bit  = 0;
    localparam int status_exl_bit = 1;

    // primary opcode field
    localparam logic [5:0] opc_special = 6'h00;
    localparam logic [5:0] opc_beq     = 6'h04;
    localparam logic [5:0] opc_bne     = 6'h05;
    localparam logic [5:0] opc_addiu   = 6'h09;
    localparam logic [5:0] opc_ori     = 6'h0d;
    localparam logic [5:0] opc_lui     = 6'h0f;
    localparam logic [5:0] opc_cop0    = 6'h10;

    // funct field
    localparam logic [5:0] fn_eret = 6'h18;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_slt  = 6'h2a;

    // rs field under cop0
    localparam reg_addr_t cop0_mf = 5'h00;
    localparam reg_addr_t cop0_mt = 5'h04;
    localparam reg_addr_t cop0_co = 5'h10;

    typedef enum logic [3:0] {
        op_nop,
        op_addu,
        op_subu,
        op_and,
        op_or,
        op_xor,
        op_slt,
        op_addiu,
        op_ori,
        op_lui,
        op_beq,
        op_bne,
        op_mfc0,
        op_mtc0,
        op_eret
    } opcode_e;

endpackage

// ==== source/exe_wb_if.sv ====
/* one executed instruction handed from execute to write-back
   wr is only meaningful while valid is high */
`timescale 1ns/1ps

interface exe_wb_if;
    logic                valid;
    core_pkg::word_t     pc;
    logic                wr;       // register write needed
    core_pkg::reg_addr_t dst;
    core_pkg::word_t     result;

    modport exe (output valid, output pc, output wr, output dst, output result);
    modport wb  (input valid, input pc, input wr, input dst, input result);
endinterface

// ==== source/cp0_if.sv ====
/* execute side and coprocessor-0 side of the CP0 block
   reads are combinational and writes land on the next edge */
`timescale 1ns/1ps

interface cp0_if;
    core_pkg::reg_addr_t rd_addr;
    logic                wr_en;
    core_pkg::reg_addr_t wr_addr;
    core_pkg::word_t     wr_data;
    logic                take_int;
    logic                eret;
    core_pkg::word_t     epc_in;     // pc of the cancelled instruction
    core_pkg::word_t     rd_data;
    logic                int_pending;
    core_pkg::word_t     epc;

    modport exe (
        output rd_addr, output wr_en, output wr_addr, output wr_data,
        output take_int, output eret, output epc_in,
        input  rd_data, input int_pending, input epc
    );
    modport cp0 (
        input  rd_addr, input wr_en, input wr_addr, input wr_data,
        input  take_int, input eret, input epc_in,
        output rd_data, output int_pending, output epc
    );
endinterface

// ==== source/fetch_stage.sv ====
/* instruction memory must answer inst_addr within the same cycle
   no stall path since fetch issues every cycle */
`timescale 1ns/1ps

module fetch_stage (
    input  logic            aclk,
    input  logic            reset,
    input  core_pkg::word_t inst_rdata,
    input  logic            redirect,
    input  core_pkg::word_t redirect_pc,
    input  logic            discard,
    output core_pkg::word_t inst_addr,
    output logic            fetch_valid,
    output core_pkg::word_t fetch_pc,
    output core_pkg::word_t fetch_instr
);
    core_pkg::word_t pc;

    assign inst_addr = pc;

    always_ff @(posedge aclk) begin
        if (reset) begin
            pc <= core_pkg::reset_vector;
        end else if (redirect) begin
            pc <= redirect_pc;     // branch target, exc vector or epc
        end else begin
            pc <= pc + 32'd4;
        end
    end

    // discard drops the word returned alongside an interrupt or eret
    always_ff @(posedge aclk) begin
        if (reset || discard) begin
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        fetch_pc    <= pc;
        fetch_instr <= inst_rdata;
    end

endmodule

// ==== source/reg_file.sv ====
/* 32 x 32-bit general registers with two combinational reads
   register 0 reads zero and ignores writes */
`timescale 1ns/1ps

module reg_file (
    input  logic                aclk,
    input  logic                reset,
    input  core_pkg::reg_addr_t rs_addr,
    input  core_pkg::reg_addr_t rt_addr,
    input  logic                wr_en,
    input  core_pkg::reg_addr_t wr_addr,
    input  core_pkg::word_t     wr_data,
    output core_pkg::word_t     rs_data,
    output core_pkg::word_t     rt_data
);
    core_pkg::word_t regs [32];

    // nothing retires while reset is high
    always_ff @(posedge aclk) begin
        if (!reset && wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

// ==== source/decode_execute.sv ====
/* decode, operand forwarding, ALU, branch resolve and interrupt take in one cycle
   branches keep one delay slot and an interrupt never lands on a delay slot */
`timescale 1ns/1ps

module decode_execute (
    input  logic                aclk,
    input  logic                reset,
    input  logic                fetch_valid,
    input  core_pkg::word_t     fetch_pc,
    input  core_pkg::word_t     fetch_instr,
    input  logic                wb_wr,
    input  core_pkg::reg_addr_t wb_dst,
    input  core_pkg::word_t     wb_result,
    input  core_pkg::word_t     rs_data,
    input  core_pkg::word_t     rt_data,
    output core_pkg::reg_addr_t rs_addr,
    output core_pkg::reg_addr_t rt_addr,
    output logic                redirect,
    output core_pkg::word_t     redirect_pc,
    output logic                discard,
    exe_wb_if.exe               ewb,
    cp0_if.exe                  cp0
);
    core_pkg::opcode_e   op;
    core_pkg::reg_addr_t rd_addr;
    core_pkg::word_t     imm_sext;
    core_pkg::word_t     src_a;
    core_pkg::word_t     src_b;
    core_pkg::word_t     result;
    core_pkg::word_t     branch_target;
    logic                writes;
    logic                in_delay_slot;
    logic                take_int;
    logic                exec_valid;
    logic                is_branch;
    logic                branch_taken;
    logic                eret_exec;

    assign rs_addr  = fetch_instr[25:21];
    assign rt_addr  = fetch_instr[20:16];
    assign rd_addr  = fetch_instr[15:11];
    assign imm_sext = {{16{fetch_instr[15]}}, fetch_instr[15:0]};

    always_comb begin
        op = core_pkg::op_nop;
        case (fetch_instr[31:26])
            core_pkg::opc_special: begin
                case (fetch_instr[5:0])
                    core_pkg::fn_addu: op = core_pkg::op_addu;
                    core_pkg::fn_subu: op = core_pkg::op_subu;
                    core_pkg::fn_and:  op = core_pkg::op_and;
                    core_pkg::fn_or:   op = core_pkg::op_or;
                    core_pkg::fn_xor:  op = core_pkg::op_xor;
                    core_pkg::fn_slt:  op = core_pkg::op_slt;
                    default:           op = core_pkg::op_nop;
                endcase
            end
            core_pkg::opc_addiu: op = core_pkg::op_addiu;
            core_pkg::opc_ori:   op = core_pkg::op_ori;
            core_pkg::opc_lui:   op = core_pkg::op_lui;
            core_pkg::opc_beq:   op = core_pkg::op_beq;
            core_pkg::opc_bne:   op = core_pkg::op_bne;
            core_pkg::opc_cop0: begin
                if (rs_addr == core_pkg::cop0_mf) begin
                    op = core_pkg::op_mfc0;
                end else if (rs_addr == core_pkg::cop0_mt) begin
                    op = core_pkg::op_mtc0;
                end else if (rs_addr == core_pkg::cop0_co && fetch_instr[5:0] == core_pkg::fn_eret) begin
                    op = core_pkg::op_eret;
                end
            end
            default: op = core_pkg::op_nop;
        endcase
    end

    // write-back result beats the register file, never for $0
    assign src_a = (wb_wr && wb_dst != '0 && wb_dst == rs_addr) ? wb_result : rs_data;
    assign src_b = (wb_wr && wb_dst != '0 && wb_dst == rt_addr) ? wb_result : rt_data;

    always_comb begin
        result = '0;
        writes = 1'b1;
        case (op)
            core_pkg::op_addu:  result = src_a + src_b;
            core_pkg::op_subu:  result = src_a - src_b;
            core_pkg::op_and:   result = src_a & src_b;
            core_pkg::op_or:    result = src_a | src_b;
            core_pkg::op_xor:   result = src_a ^ src_b;
            core_pkg::op_slt:   result = {31'b0, $signed(src_a) < $signed(src_b)};
            core_pkg::op_addiu: result = src_a + imm_sext;
            core_pkg::op_ori:   result = src_a | {16'h0, fetch_instr[15:0]};
            core_pkg::op_lui:   result = {fetch_instr[15:0], 16'h0};
            core_pkg::op_mfc0:  result = cp0.rd_data;
            default:            writes = 1'b0;    // branches, mtc0, eret, nop
        endcase
    end

    assign take_int   = fetch_valid & cp0.int_pending & ~in_delay_slot;
    assign exec_valid = fetch_valid & ~take_int;    // cancelled instr commits nothing

    assign is_branch     = (op == core_pkg::op_beq) || (op == core_pkg::op_bne);
    assign branch_taken  = exec_valid &
                           (((op == core_pkg::op_beq) && (src_a == src_b)) ||
                            ((op == core_pkg::op_bne) && (src_a != src_b)));
    assign branch_target = fetch_pc + 32'd4 + {imm_sext[29:0], 2'b00};
    assign eret_exec     = exec_valid & (op == core_pkg::op_eret);

    // next instruction in execute is the delay slot
    always_ff @(posedge aclk) begin
        if (reset) begin
            in_delay_slot <= 1'b0;
        end else begin
            in_delay_slot <= exec_valid & is_branch;
        end
    end

    assign redirect    = take_int | eret_exec | branch_taken;
    assign redirect_pc = take_int  ? core_pkg::exc_vector :
                         eret_exec ? cp0.epc : branch_target;
    assign discard     = take_int | eret_exec;

    assign cp0.rd_addr  = rd_addr;
    assign cp0.wr_en    = exec_valid & (op == core_pkg::op_mtc0);
    assign cp0.wr_addr  = rd_addr;
    assign cp0.wr_data  = src_b;
    assign cp0.take_int = take_int;
    assign cp0.eret     = eret_exec;
    assign cp0.epc_in   = fetch_pc;

    assign ewb.valid  = exec_valid;
    assign ewb.pc     = fetch_pc;
    assign ewb.wr     = writes;
    assign ewb.dst    = (fetch_instr[31:26] == core_pkg::opc_special) ? rd_addr : rt_addr;
    assign ewb.result = result;

endmodule

// ==== source/cp0_regs.sv ====
/* Status, Cause and EPC only, with interrupts as the sole exception source
   Status.EXL changes only on interrupt entry and eret */
`timescale 1ns/1ps

module cp0_regs (
    input  logic                           aclk,
    input  logic                           reset,
    input  logic [core_pkg::int_width-1:0] ext_int,
    cp0_if.cp0                             cp0
);
    core_pkg::word_t status;
    core_pkg::word_t cause;
    core_pkg::word_t epc;

    always_ff @(posedge aclk) begin
        if (reset) begin
            status <= '0;
        end else begin
            if (cp0.wr_en && cp0.wr_addr == core_pkg::cp0_status) begin
                status[15:8]                   <= cp0.wr_data[15:8];    // IM
                status[core_pkg::status_ie_bit] <= cp0.wr_data[core_pkg::status_ie_bit];
            end
            if (cp0.take_int) begin
                status[core_pkg::status_exl_bit] <= 1'b1;
            end else if (cp0.eret) begin
                status[core_pkg::status_exl_bit] <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            cause <= '0;
        end else begin
            cause[10 +: core_pkg::int_width] <= ext_int;    // IP7..IP2, one flop
            if (cp0.wr_en && cp0.wr_addr == core_pkg::cp0_cause) begin
                cause[9:8] <= cp0.wr_data[9:8];    // software interrupts
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (cp0.take_int) begin
            epc <= cp0.epc_in;
        end else if (cp0.wr_en && cp0.wr_addr == core_pkg::cp0_epc) begin
            epc <= cp0.wr_data;
        end
    end

    assign cp0.int_pending = status[core_pkg::status_ie_bit] &
                             ~status[core_pkg::status_exl_bit] &
                             (|(cause[15:8] & status[15:8]));

    always_comb begin
        case (cp0.rd_addr)
            core_pkg::cp0_status: cp0.rd_data = status;
            core_pkg::cp0_cause:  cp0.rd_data = cause;
            core_pkg::cp0_epc:    cp0.rd_data = epc;
            default:              cp0.rd_data = '0;
        endcase
    end

    assign cp0.epc = epc;

endmodule

// ==== source/writeback_stage.sv ====
/* last pipeline register, feeding the register file, forwarding and golden trace
   a write to $0 still shows on the trace */
`timescale 1ns/1ps

module writeback_stage (
    input  logic                aclk,
    input  logic                reset,
    exe_wb_if.wb                ewb,
    output logic                wb_wr,
    output core_pkg::reg_addr_t wb_dst,
    output core_pkg::word_t     wb_result,
    output core_pkg::word_t     debug_wb_pc,
    output core_pkg::word_t     debug_wb_rf_wdata,
    output logic [3:0]          debug_wb_rf_wen,
    output core_pkg::reg_addr_t debug_wb_rf_wnum
);
    logic                wr_q;
    core_pkg::word_t     pc_q;
    core_pkg::reg_addr_t dst_q;
    core_pkg::word_t     result_q;

    always_ff @(posedge aclk) begin
        if (reset) begin
            wr_q <= 1'b0;
        end else begin
            wr_q <= ewb.valid & ewb.wr;
        end
    end

    always_ff @(posedge aclk) begin
        pc_q     <= ewb.pc;
        dst_q    <= ewb.dst;
        result_q <= ewb.result;
    end

    assign wb_wr     = wr_q;
    assign wb_dst    = dst_q;
    assign wb_result = result_q;

    assign debug_wb_pc       = pc_q;
    assign debug_wb_rf_wdata = result_q;
    assign debug_wb_rf_wen   = {4{wr_q}};    // whole word or nothing
    assign debug_wb_rf_wnum  = dst_q;

endmodule

// ==== source/mycpu_top.sv ====
/* three-step MIPS subset core with a same-cycle instruction port
   no data memory, so the trace port is the only visible result */
`timescale 1ns/1ps

module mycpu_top (
    input  logic                           aclk,
    input  logic                           reset,
    input  logic [core_pkg::int_width-1:0] ext_int,
    input  core_pkg::word_t                inst_rdata,
    output core_pkg::word_t                inst_addr,
    output core_pkg::word_t                debug_wb_pc,
    output core_pkg::word_t                debug_wb_rf_wdata,
    output logic [3:0]                     debug_wb_rf_wen,
    output core_pkg::reg_addr_t            debug_wb_rf_wnum
);
    logic                redirect;
    core_pkg::word_t     redirect_pc;
    logic                discard;
    logic                fetch_valid;
    core_pkg::word_t     fetch_pc;
    core_pkg::word_t     fetch_instr;
    core_pkg::reg_addr_t rs_addr;
    core_pkg::reg_addr_t rt_addr;
    core_pkg::word_t     rs_data;
    core_pkg::word_t     rt_data;
    logic                wb_wr;      // also the regfile write port
    core_pkg::reg_addr_t wb_dst;
    core_pkg::word_t     wb_result;

    exe_wb_if ewb_bus ();
    cp0_if    cp0_bus ();

    fetch_stage u_fetch_stage (
        .aclk        (aclk),
        .reset       (reset),
        .inst_rdata  (inst_rdata),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .discard     (discard),
        .inst_addr   (inst_addr),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_instr (fetch_instr)
    );

    decode_execute u_decode_execute (
        .aclk        (aclk),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_instr (fetch_instr),
        .wb_wr       (wb_wr),
        .wb_dst      (wb_dst),
        .wb_result   (wb_result),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .discard     (discard),
        .ewb         (ewb_bus.exe),
        .cp0         (cp0_bus.exe)
    );

    reg_file u_reg_file (
        .aclk    (aclk),
        .reset   (reset),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .wr_en   (wb_wr),
        .wr_addr (wb_dst),
        .wr_data (wb_result),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    cp0_regs u_cp0_regs (
        .aclk    (aclk),
        .reset   (reset),
        .ext_int (ext_int),
        .cp0     (cp0_bus.cp0)
    );

    writeback_stage u_writeback_stage (
        .aclk              (aclk),
        .reset             (reset),
        .ewb               (ewb_bus.wb),
        .wb_wr             (wb_wr),
        .wb_dst            (wb_dst),
        .wb_result         (wb_result),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum)
    );

endmodule

// ==== test/mycpu_checker.sv ====
/* concurrent checks on the fetch and trace ports of mycpu_top
   checks start at the first clock edge, reset must be high there */
`timescale 1ns/1ps

module mycpu_checker (
    input logic            aclk,
    input logic            reset,
    input core_pkg::word_t inst_addr,
    input logic [3:0]      debug_wb_rf_wen
);
    int fail_count = 0;

    // whole word or nothing
    wen_full_word: assert property (@(posedge aclk) disable iff (reset)
        debug_wb_rf_wen == 4'h0 || debug_wb_rf_wen == 4'hf)
        else begin
            fail_count++;
            $error("debug_wb_rf_wen is %b, neither 0 nor all ones", debug_wb_rf_wen);
        end

    wen_quiet_in_reset: assert property (@(posedge aclk) $past(reset) |-> debug_wb_rf_wen == 4'h0)
        else begin
            fail_count++;
            $error("debug_wb_rf_wen set right after a reset edge");
        end

    fetch_aligned: assert property (@(posedge aclk) disable iff (reset) inst_addr[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("inst_addr %h is not word aligned", inst_addr);
        end

    first_fetch: assert property (@(posedge aclk)
        $fell(reset) |-> inst_addr == core_pkg::reset_vector)
        else begin
            fail_count++;
            $error("first inst_addr after reset is %h", inst_addr);
        end

endmodule

// ==== test/tb_top.sv ====
/* runs mycpu_top from a same-cycle instruction table and checks the golden trace
   only the 1 KB boot window decodes, every other address reads as nop */
`timescale 1ns/1ps

module tb_top;
    localparam int seed      = 64353;
    localparam int mem_words = 256;
    localparam int num_tests = 5;
    localparam int loop_len  = 40;    // straight addiu run before the back branch
    localparam int post_ret  = 4;     // loop entries checked after eret

    logic                           aclk;
    logic                           reset;
    logic [core_pkg::int_width-1:0] ext_int;
    core_pkg::word_t                inst_rdata;
    core_pkg::word_t                inst_addr;
    core_pkg::word_t                debug_wb_pc;
    core_pkg::word_t                debug_wb_rf_wdata;
    logic [3:0]                     debug_wb_rf_wen;
    core_pkg::reg_addr_t            debug_wb_rf_wnum;

    core_pkg::word_t     imem [mem_words];
    core_pkg::word_t     model_rf [32];    // reference register values
    core_pkg::word_t     exp_pc [$];
    core_pkg::reg_addr_t exp_reg [$];
    core_pkg::word_t     exp_data [$];
    int                  exp_test [$];
    int                  test_errors [num_tests+1];
    string               test_name [num_tests+1] = '{"", "reset", "alu chain", "branches",
                                                      "cp0 moves", "interrupt"};
    int                  errors;
    int                  slot;
    int                  cur_test;
    int                  limit_cycles = 0;
    core_pkg::word_t     loop_pc;
    core_pkg::word_t     loop_val;
    core_pkg::word_t     epc_seen;
    logic                entered;

    mycpu_top dut (
        .aclk              (aclk),
        .reset             (reset),
        .ext_int           (ext_int),
        .inst_rdata        (inst_rdata),
        .inst_addr         (inst_addr),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum)
    );

    bind mycpu_top mycpu_checker u_checker (
        .aclk            (aclk),
        .reset           (reset),
        .inst_addr       (inst_addr),
        .debug_wb_rf_wen (debug_wb_rf_wen)
    );

    assign inst_rdata = (inst_addr[31:10] == core_pkg::reset_vector[31:10]) ?
                        imem[inst_addr[9:2]] : 32'h0;

    initial aclk = 1'b0;
    always #20 aclk = ~aclk;

    function automatic core_pkg::word_t sext(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    function automatic core_pkg::word_t enc_r(input logic [4:0] rs, input logic [4:0] rt,
                                              input logic [4:0] rd, input logic [5:0] fn);
        return {6'h00, rs, rt, rd, 5'h00, fn};
    endfunction

    function automatic core_pkg::word_t enc_i(input logic [5:0] opc, input logic [4:0] rs,
                                              input logic [4:0] rt, input logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    function automatic core_pkg::word_t enc_cop0(input logic [4:0] sub, input logic [4:0] rt,
                                                 input logic [4:0] rd);
        return {6'h10, sub, rt, rd, 11'h000};
    endfunction

    task automatic place(input core_pkg::word_t instr);
        imem[slot] = instr;
        slot++;
    endtask

    // word plus the trace entry it must produce
    task automatic emit(input core_pkg::word_t instr, input core_pkg::reg_addr_t dst,
                        input core_pkg::word_t val);
        exp_pc.push_back(core_pkg::reset_vector + 32'(slot * 4));
        exp_reg.push_back(dst);
        exp_data.push_back(val);
        exp_test.push_back(cur_test);
        if (dst != 0) begin
            model_rf[dst] = val;    // $0 keeps zero
        end
        place(instr);
    endtask

    task automatic build_program();
        logic [15:0] r0, r1, r2, r3, r4, r5;
        int          hnd;
        r0 = $urandom;
        r1 = $urandom;
        r2 = $urandom;
        r3 = $urandom;
        r4 = $urandom;
        r5 = $urandom;
        for (int i = 0; i < mem_words; i++) begin
            imem[i] = 32'h0;
        end
        for (int i = 0; i < 32; i++) begin
            model_rf[i] = 32'h0;
        end
        slot = 0;
        cur_test = 2;    // each step reads the one just before
        emit(enc_i(6'h0f, 0, 1, r0), 1, {r0, 16'h0});
        emit(enc_i(6'h0d, 1, 2, r1), 2, model_rf[1] | {16'h0, r1});
        emit(enc_i(6'h09, 2, 3, r2), 3, model_rf[2] + sext(r2));
        emit(enc_r(3, 2, 4, 6'h21), 4, model_rf[3] + model_rf[2]);
        emit(enc_r(4, 1, 5, 6'h23), 5, model_rf[4] - model_rf[1]);
        emit(enc_r(5, 3, 6, 6'h24), 6, model_rf[5] & model_rf[3]);
        emit(enc_r(6, 1, 7, 6'h25), 7, model_rf[6] | model_rf[1]);
        emit(enc_r(7, 2, 8, 6'h26), 8, model_rf[7] ^ model_rf[2]);
        emit(enc_r(8, 4, 9, 6'h2a), 9, {31'h0, $signed(model_rf[8]) < $signed(model_rf[4])});
        cur_test = 3;
        emit(enc_i(6'h09, 0, 10, r3), 10, sext(r3));
        place(enc_i(6'h04, 10, 10, 16'd2));                           // beq taken, skips one
        emit(enc_i(6'h09, 10, 11, 16'h0011), 11, model_rf[10] + 32'h11);  // delay slot
        place(enc_i(6'h09, 0, 12, 16'h0001));                          // must never retire
        emit(enc_i(6'h09, 11, 12, 16'h0022), 12, model_rf[11] + 32'h22);  // branch target
        place(enc_i(6'h05, 12, 12, 16'd8));                            // bne not taken
        emit(enc_i(6'h09, 12, 13, 16'h0033), 13, model_rf[12] + 32'h33);
        emit(enc_i(6'h09, 13, 14, 16'h0044), 14, model_rf[13] + 32'h44);
        cur_test = 4;
        emit(enc_i(6'h0d, 0, 15, r4), 15, {16'h0, r4});
        place(enc_cop0(5'h04, 15, 12));                                // mtc0 status
        emit(enc_cop0(5'h00, 16, 12), 16, {16'h0, r4} & 32'h0000_ff01);   // IM and IE only
        emit(enc_i(6'h09, 16, 0, r1), 0, model_rf[16] + sext(r1));     // trace shows $0
        emit(enc_r(0, 0, 17, 6'h21), 17, 32'h0);
        emit(enc_r(0, 16, 18, 6'h25), 18, model_rf[16]);
        cur_test = 5;
        emit(enc_i(6'h0d, 0, 19, 16'h0401), 19, 32'h0000_0401);        // IM2 and IE
        place(enc_cop0(5'h04, 19, 12));
        emit(enc_i(6'h09, 0, 20, r5), 20, sext(r5));
        for (int i = 0; i < loop_len; i++) begin
            place(enc_i(6'h09, 20, 20, 16'h0001));
        end
        place(enc_i(6'h04, 0, 0, 16'(-(loop_len + 1))));                // back to loop start
        place(enc_i(6'h09, 20, 20, 16'h0001));
        hnd = (core_pkg::exc_vector - core_pkg::reset_vector) >> 2;
        imem[hnd]     = enc_cop0(5'h00, 21, 14);    // mfc0 $21, epc
        imem[hnd + 1] = 32'h0;
        imem[hnd + 2] = 32'h4200_0018;              // eret
    endtask

    task automatic check_word(input core_pkg::word_t got, input core_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
            test_errors[cur_test]++;
        end
    endtask

    task automatic check_reg(input core_pkg::reg_addr_t got, input core_pkg::reg_addr_t exp,
                             input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
            test_errors[cur_test]++;
        end
    endtask

    task automatic next_entry();
        do begin
            @(negedge aclk);
        end while (debug_wb_rf_wen === 4'h0);
    endtask

    task automatic check_loop_step();
        check_word(debug_wb_pc, loop_pc + 32'd4, "loop pc");
        check_reg(debug_wb_rf_wnum, 5'd20, "loop register");
        check_word(debug_wb_rf_wdata, loop_val + 32'd1, "loop count");
        loop_pc  = loop_pc + 32'd4;
        loop_val = loop_val + 32'd1;
    endtask

    task automatic report_test(input int id);
        if (test_errors[id] == 0) begin
            $display("test %0d %s: ok", id, test_name[id]);
        end else begin
            $display("test %0d %s: %0d errors", id, test_name[id], test_errors[id]);
        end
    endtask

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge aclk);
        $display("timeout: trace stopped after %0d cycles", limit_cycles);
        $display("Verification failed");
        $finish;
    end

    initial begin
        reset   = 1'b1;
        ext_int = '0;
        errors  = 0;
        void'($urandom(seed));
        build_program();
        limit_cycles = (exp_pc.size() + slot) * 4 + 200;
        cur_test = 1;
        repeat (16) begin
            @(posedge aclk);
            #2;
            if (debug_wb_rf_wen !== 4'h0) begin
                $display("trace write seen at %0t while reset was high", $time);
                errors++;
                test_errors[1]++;
            end
        end
        reset = 1'b0;
        @(negedge aclk);
        check_word(inst_addr, core_pkg::reset_vector, "first fetch address");
        report_test(1);

        for (int i = 0; i < exp_pc.size(); i++) begin
            cur_test = exp_test[i];
            next_entry();
            check_word(debug_wb_pc, exp_pc[i], "trace pc");
            check_reg(debug_wb_rf_wnum, exp_reg[i], "trace register");
            check_word(debug_wb_rf_wdata, exp_data[i], "trace data");
            if ((i + 1 == exp_pc.size() || exp_test[i + 1] != cur_test) && cur_test != 5) begin
                report_test(cur_test);
            end
        end

        loop_pc  = exp_pc[$];
        loop_val = model_rf[20];
        for (int n = 0; n < 4; n++) begin
            next_entry();
            check_loop_step();
        end
        @(posedge aclk);
        #2 ext_int[0] = 1'b1;
        entered = 1'b0;
        for (int n = 0; n < loop_len; n++) begin
            next_entry();
            if (debug_wb_pc === core_pkg::exc_vector) begin
                entered = 1'b1;
                break;
            end
            check_loop_step();
        end
        if (!entered) begin
            $display("interrupt on ext_int[0] was never taken");
            errors++;
            test_errors[5]++;
        end else begin
            epc_seen = debug_wb_rf_wdata;
            check_reg(debug_wb_rf_wnum, 5'd21, "handler register");
            check_word(epc_seen, loop_pc + 32'd4, "epc after last committed pc");
            @(posedge aclk);
            #2 ext_int = '0;    // cleared inside the handler
            next_entry();
            check_word(debug_wb_pc, epc_seen, "first pc after eret");
            loop_pc = epc_seen - 32'd4;
            check_loop_step();
            for (int n = 0; n < post_ret; n++) begin
                next_entry();
                check_loop_step();
            end
        end
        report_test(5);

        errors += dut.u_checker.fail_count;
        $display("%0d tests, %0d errors, %0d assertion failures",
                 num_tests, errors, dut.u_checker.fail_count);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
source/core_pkg.sv
source/exe_wb_if.sv
source/cp0_if.sv
source/fetch_stage.sv
source/reg_file.sv
source/decode_execute.sv
source/cp0_regs.sv
source/writeback_stage.sv
source/mycpu_top.sv
test/mycpu_checker.sv
test/tb_top.sv

// ==== Bender.yml ====
package:
  name: mycpu

sources:
  - files:
      - source/core_pkg.sv
      - source/exe_wb_if.sv
      - source/cp0_if.sv
      - source/fetch_stage.sv
      - source/reg_file.sv
      - source/decode_execute.sv
      - source/cp0_regs.sv
      - source/writeback_stage.sv
      - source/mycpu_top.sv
  - target: test
    files:
      - test/mycpu_checker.sv
      - test/tb_top.sv
